// ==== source/fp32_rnd_pkg.sv ====
// fp32 rounding back end, shared constants
// widths, special encodings, status flag positions and rounding-mode codes
package fp32_rnd_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int FRACT_IN_W = 28;  // unit fraction incl. carry and {r,s}
  localparam int FRACT_W    = 32;  // aligned fraction word
  localparam int EXP_W      = 10;  // internal exponent, room for overflow
  localparam int SHIFT_W    = 5;
  localparam int FLAG_W     = 9;

  //////////////////////////////////////////////////
  // flag bit positions
  //////////////////////////////////////////////////
  localparam int FLG_DBZ  = 8;  // divide by zero
  localparam int FLG_INF  = 7;
  localparam int FLG_INV  = 6;
  localparam int FLG_INE  = 5;  // inexact
  localparam int FLG_ZER  = 4;
  localparam int FLG_QNAN = 3;
  localparam int FLG_SNAN = 2;
  localparam int FLG_UNF  = 1;
  localparam int FLG_OVF  = 0;

  //////////////////////////////////////////////////
  // special encodings, sign bit excluded
  //////////////////////////////////////////////////
  localparam logic [EXP_W-1:0] EXP_MAX_NORMAL = 10'd254;
  localparam logic [30:0] INF_BITS  = 31'h7f80_0000;
  localparam logic [30:0] QNAN_BITS = 31'h7fc0_0000;
  localparam logic [30:0] SNAN_BITS = 31'h7fbf_ffff;  // all-ones payload

  // rounding modes
  localparam logic [1:0] RM_NEAREST = 2'd0;
  localparam logic [1:0] RM_TO_ZERO = 2'd1;
  localparam logic [1:0] RM_TO_INFP = 2'd2;
  localparam logic [1:0] RM_TO_INFM = 2'd3;

endpackage

// ==== source/fp32_align.sv ====
// fp32 rounding, stage one
// picks the ready unit, aligns the fraction, builds round/sticky,
// selects the exponent and registers everything on adv_i
`timescale 1ns/1ps

module fp32_align import fp32_rnd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush_i,
  input  logic                  adv_i,
  input  logic [1:0]            rmode_i,
  // add/sub unit
  input  logic                  add_rdy_i,
  input  logic                  add_sign_i,
  input  logic                  add_sub_0_i,     // true sub, zero result
  input  logic [SHIFT_W-1:0]    add_shl_i,
  input  logic [EXP_W-1:0]      add_exp_shl_i,
  input  logic [EXP_W-1:0]      add_exp_sh0_i,
  input  logic [FRACT_IN_W-1:0] add_fract_i,
  input  logic                  add_inv_i,
  input  logic                  add_inf_i,
  input  logic                  add_snan_i,
  input  logic                  add_qnan_i,
  input  logic                  add_anan_sign_i,
  // mul/div unit
  input  logic                  mul_rdy_i,
  input  logic                  mul_sign_i,
  input  logic [SHIFT_W-1:0]    mul_shr_i,
  input  logic [EXP_W-1:0]      mul_exp_shr_i,
  input  logic                  mul_shl_i,
  input  logic [EXP_W-1:0]      mul_exp_shl_i,
  input  logic [EXP_W-1:0]      mul_exp_sh0_i,
  input  logic [FRACT_IN_W-1:0] mul_fract_i,
  input  logic                  mul_inv_i,
  input  logic                  mul_inf_i,
  input  logic                  mul_snan_i,
  input  logic                  mul_qnan_i,
  input  logic                  mul_anan_sign_i,
  input  logic                  div_op_i,
  input  logic                  div_sign_rmnd_i,
  input  logic                  div_dbz_i,
  // stage one registers
  output logic                  s1_valid_o,
  output logic                  s1_sign_o,
  output logic [EXP_W-1:0]      s1_exp_o,
  output logic [FRACT_W-1:0]    s1_fract_o,
  output logic                  s1_round_o,
  output logic                  s1_sticky_o,
  output logic                  s1_inv_o,
  output logic                  s1_inf_o,
  output logic                  s1_snan_o,
  output logic                  s1_qnan_o,
  output logic                  s1_anan_sign_o,
  output logic                  s1_div_op_o,
  output logic                  s1_div_rmnd_o,
  output logic                  s1_dbz_o
);

  localparam int SH_W = FRACT_W + 3;  // aligned word, round bit, two spare

  logic                  add_sign;
  logic [FRACT_IN_W-1:0] t_fract;
  logic [SH_W-1:0]       t_shifted;
  logic [SHIFT_W-1:0]    t_shr_req;   // shift asked for by the unit
  logic [SHIFT_W-1:0]    t_shr;
  logic [SHIFT_W-1:0]    t_shl;
  logic                  t_carry;
  logic                  sticky_r;
  logic                  sticky_l;
  logic [EXP_W-1:0]      t_exp;

  // zero from true subtraction is -0 only when rounding down
  assign add_sign = add_sub_0_i ? (rmode_i == RM_TO_INFM) : add_sign_i;

  assign t_fract   = add_rdy_i ? add_fract_i : mul_fract_i;
  assign t_carry   = t_fract[FRACT_IN_W-1];  // overflow out of the unit
  assign t_shr_req = add_rdy_i ? '0 : mul_shr_i;
  assign t_shl     = add_rdy_i ? add_shl_i : {{(SHIFT_W-1){1'b0}}, mul_shl_i};
  assign t_shr     = (|t_shr_req) ? t_shr_req : {{(SHIFT_W-1){1'b0}}, t_carry};

  //////////////////////////////////////////////////
  // align
  //////////////////////////////////////////////////
  assign t_shifted = (|t_shr) ? ({{(SH_W-FRACT_IN_W){1'b0}}, t_fract} >> t_shr)
                              : ({{(SH_W-FRACT_IN_W){1'b0}}, t_fract} << t_shl);

  // right shift: bits [shr+1:0] drop below round, shr>=26 takes them all
  always_comb begin
    sticky_r = 1'b0;
    for (int i = 0; i < FRACT_IN_W; i++) begin
      if (i <= int'(t_shr) + 1)
        sticky_r = sticky_r | t_fract[i];
    end
  end

  // left shift pulls the low bits back up
  always_comb begin
    case (t_shl)
      5'd0:    sticky_l = |t_fract[1:0];
      5'd1:    sticky_l = t_fract[0];
      default: sticky_l = 1'b0;
    endcase
  end

  // exponent follows the shift actually applied
  always_comb begin
    if (|t_shr_req)
      t_exp = mul_exp_shr_i;  // add never shifts right on request
    else if (t_shl == '0)
      t_exp = (add_rdy_i ? add_exp_sh0_i : mul_exp_sh0_i) + {{(EXP_W-1){1'b0}}, t_carry};
    else
      t_exp = add_rdy_i ? add_exp_shl_i : mul_exp_shl_i;
  end

  //////////////////////////////////////////////////
  // stage registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      s1_valid_o <= 1'b0;
    else if (flush_i)
      s1_valid_o <= 1'b0;
    else if (adv_i)
      s1_valid_o <= add_rdy_i | mul_rdy_i;
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_sign_o      <= add_rdy_i ? add_sign : mul_sign_i;
      s1_exp_o       <= t_exp;
      s1_fract_o     <= t_shifted[SH_W-1:3];
      s1_round_o     <= t_shifted[2];
      s1_sticky_o    <= (|t_shr) ? sticky_r : sticky_l;
      s1_inv_o       <= add_rdy_i ? add_inv_i : mul_inv_i;
      s1_inf_o       <= add_rdy_i ? add_inf_i : mul_inf_i;
      s1_snan_o      <= add_rdy_i ? add_snan_i : mul_snan_i;
      s1_qnan_o      <= add_rdy_i ? add_qnan_i : mul_qnan_i;
      s1_anan_sign_o <= add_rdy_i ? add_anan_sign_i : mul_anan_sign_i;
      s1_div_op_o    <= mul_rdy_i & div_op_i;
      s1_div_rmnd_o  <= div_sign_rmnd_i;
      s1_dbz_o       <= div_dbz_i;
    end
  end

endmodule

// ==== source/fp32_round.sv ====
// fp32 rounding, stage two decision
// rounding increment or quotient decrement, then post-round renormalize
`timescale 1ns/1ps

module fp32_round import fp32_rnd_pkg::*; (
  input  logic [1:0]         rmode_i,
  input  logic               s1_sign_i,
  input  logic [EXP_W-1:0]   s1_exp_i,
  input  logic [FRACT_W-1:0] s1_fract_i,
  input  logic               s1_round_i,
  input  logic               s1_sticky_i,
  input  logic               s1_div_op_i,
  input  logic               s1_div_rmnd_i,  // remainder sign
  output logic [EXP_W-1:0]   rnd_exp_o,
  output logic [23:0]        rnd_fract_o,
  output logic               lost_o
);

  logic               rm_nearest;
  logic               rm_to_zero;
  logic               rm_to_infp;
  logic               rm_to_infm;
  logic               rnd_up;
  logic               div_up;
  logic               div_dn;
  logic               n_qtnt;
  logic [FRACT_W-1:0] fract_rnd;
  logic               carry;

  assign rm_nearest = (rmode_i == RM_NEAREST);
  assign rm_to_zero = (rmode_i == RM_TO_ZERO);
  assign rm_to_infp = (rmode_i == RM_TO_INFP);
  assign rm_to_infm = (rmode_i == RM_TO_INFM);

  assign lost_o = s1_round_i | s1_sticky_i;

  // common rule, ties go to even via guard
  assign rnd_up = (rm_nearest & s1_round_i & (s1_sticky_i | s1_fract_i[0])) |
                  (rm_to_infp & ~s1_sign_i & lost_o) |
                  (rm_to_infm &  s1_sign_i & lost_o);

  //////////////////////////////////////////////////
  // quotient rules
  //////////////////////////////////////////////////
  // sticky alone means a nonzero remainder, its sign says which side
  assign div_up = (rm_nearest & s1_round_i & s1_sticky_i & ~s1_div_rmnd_i) |
                  (((rm_to_infp & ~s1_sign_i) | (rm_to_infm & s1_sign_i)) &
                   ((s1_round_i & s1_sticky_i) |
                    (~s1_round_i & s1_sticky_i & ~s1_div_rmnd_i)));
  assign div_dn = ~s1_round_i & s1_sticky_i & s1_div_rmnd_i &
                  ((rm_to_infp & s1_sign_i) | (rm_to_infm & ~s1_sign_i) | rm_to_zero);

  assign n_qtnt = s1_div_op_i & s1_fract_i[23];  // normalized quotient

  always_comb begin
    if (n_qtnt ? div_up : rnd_up)
      fract_rnd = s1_fract_i + FRACT_W'(1);
    else if (n_qtnt & div_dn)
      fract_rnd = s1_fract_i - FRACT_W'(1);
    else
      fract_rnd = s1_fract_i;
  end

  // carry into bit 24 renormalizes by one
  assign carry       = fract_rnd[24];
  assign rnd_exp_o   = s1_exp_i + {{(EXP_W-1){1'b0}}, carry};
  assign rnd_fract_o = carry ? fract_rnd[24:1] : fract_rnd[23:0];

endmodule

// ==== source/fp32_result_pack.sv ====
// fp32 rounding, result packing
// special-case priority, final single-precision word and raw status flags
`timescale 1ns/1ps

module fp32_result_pack import fp32_rnd_pkg::*; (
  input  logic               s1_sign_i,
  input  logic               s1_inv_i,
  input  logic               s1_inf_i,
  input  logic               s1_snan_i,
  input  logic               s1_qnan_i,
  input  logic               s1_anan_sign_i,
  input  logic               s1_dbz_i,
  input  logic [EXP_W-1:0]   rnd_exp_i,
  input  logic [23:0]        rnd_fract_i,
  input  logic               lost_i,
  output logic [31:0]        result_o,
  output logic [FLAG_W-1:0]  flags_o
);

  logic inf_res;
  logic ine;
  logic ovf;
  logic unf;
  logic zer;

  always_comb begin
    result_o = {s1_sign_i, rnd_exp_i[7:0], rnd_fract_i[22:0]};  // normal
    inf_res  = 1'b0;
    ine      = lost_i;
    ovf      = 1'b0;
    unf      = 1'b0;
    zer      = 1'b0;
    if (s1_snan_i | s1_qnan_i) begin
      result_o = {s1_anan_sign_i, QNAN_BITS};  // nan in, quiet nan out
      ine      = 1'b0;
    end else if (s1_inv_i) begin
      result_o = {s1_sign_i, SNAN_BITS};
      ine      = 1'b0;
    end else if ((rnd_exp_i > EXP_MAX_NORMAL) | s1_inf_i | s1_dbz_i) begin
      // exact inf operand or dbz is not an overflow
      result_o = {s1_sign_i, INF_BITS};
      inf_res  = 1'b1;
      ine      = (lost_i | ~s1_inf_i) & ~s1_dbz_i;
      ovf      = ~s1_inf_i & ~s1_dbz_i;
    end else if (!rnd_fract_i[23]) begin
      result_o = {s1_sign_i, 8'd0, rnd_fract_i[22:0]};  // denormal or zero
      unf      = lost_i;
      zer      = ~(|rnd_fract_i);
    end
  end

  // flag order dbz inf inv ine zer qnan snan unf ovf
  assign flags_o = {s1_dbz_i, inf_res, s1_inv_i, ine, zer,
                    s1_qnan_i, s1_inv_i, unf, ovf};

endmodule

// ==== source/fp32_wb_latch.sv ====
// fp32 rounding, writeback latch
// captures result and masked flags on padv_wb_i, raises the exception
// request and a one-cycle flag register update strobe
`timescale 1ns/1ps

module fp32_wb_latch import fp32_rnd_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush_i,
  input  logic              padv_wb_i,
  input  logic              grant_wb_i,
  input  logic              except_enable_i,
  input  logic [FLAG_W-1:0] flag_mask_i,
  input  logic [31:0]       result_i,
  input  logic [FLAG_W-1:0] flags_i,
  output logic [31:0]       wb_result_o,
  output logic [FLAG_W-1:0] wb_flags_o,
  output logic              wb_fpcsr_o,
  output logic              wb_except_o
);

  logic [FLAG_W-1:0] flags_m;

  assign flags_m = flags_i & flag_mask_i & {FLAG_W{grant_wb_i}};

  // result survives a flush
  always_ff @(posedge clk) begin
    if (rst)
      wb_result_o <= '0;
    else if (padv_wb_i)
      wb_result_o <= result_i & {32{grant_wb_i}};
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      wb_flags_o  <= '0;
      wb_except_o <= 1'b0;
      wb_fpcsr_o  <= 1'b0;
    end else begin
      wb_fpcsr_o <= padv_wb_i & grant_wb_i;  // single write per advance
      if (padv_wb_i) begin
        wb_flags_o  <= flags_m;
        wb_except_o <= except_enable_i & (|flags_m);
      end
    end
  end

endmodule

// ==== source/fp32_rnd_top.sv ====
// fp32 rounding back end, top level
// align stage, rounding, packing and writeback latch
`timescale 1ns/1ps

module fp32_rnd_top import fp32_rnd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush_i,
  input  logic                  adv_i,
  input  logic                  padv_wb_i,
  input  logic                  grant_wb_i,
  input  logic [1:0]            rmode_i,
  input  logic                  except_enable_i,
  input  logic [FLAG_W-1:0]     flag_mask_i,
  input  logic                  add_rdy_i,
  input  logic                  add_sign_i,
  input  logic                  add_sub_0_i,
  input  logic [SHIFT_W-1:0]    add_shl_i,
  input  logic [EXP_W-1:0]      add_exp_shl_i,
  input  logic [EXP_W-1:0]      add_exp_sh0_i,
  input  logic [FRACT_IN_W-1:0] add_fract_i,
  input  logic                  add_inv_i,
  input  logic                  add_inf_i,
  input  logic                  add_snan_i,
  input  logic                  add_qnan_i,
  input  logic                  add_anan_sign_i,
  input  logic                  mul_rdy_i,
  input  logic                  mul_sign_i,
  input  logic [SHIFT_W-1:0]    mul_shr_i,
  input  logic [EXP_W-1:0]      mul_exp_shr_i,
  input  logic                  mul_shl_i,
  input  logic [EXP_W-1:0]      mul_exp_shl_i,
  input  logic [EXP_W-1:0]      mul_exp_sh0_i,
  input  logic [FRACT_IN_W-1:0] mul_fract_i,
  input  logic                  mul_inv_i,
  input  logic                  mul_inf_i,
  input  logic                  mul_snan_i,
  input  logic                  mul_qnan_i,
  input  logic                  mul_anan_sign_i,
  input  logic                  div_op_i,
  input  logic                  div_sign_rmnd_i,
  input  logic                  div_dbz_i,
  output logic                  valid_o,
  output logic [31:0]           wb_result_o,
  output logic [FLAG_W-1:0]     wb_flags_o,
  output logic                  wb_fpcsr_o,
  output logic                  wb_except_o
);

  // stage one registers
  logic               s1_valid, s1_sign, s1_round, s1_sticky;
  logic [EXP_W-1:0]   s1_exp;
  logic [FRACT_W-1:0] s1_fract;
  logic               s1_inv, s1_inf, s1_snan, s1_qnan, s1_anan_sign;
  logic               s1_div_op, s1_div_rmnd, s1_dbz;
  // stage two
  logic [EXP_W-1:0]   rnd_exp;
  logic [23:0]        rnd_fract;
  logic               lost;
  logic [31:0]        result;
  logic [FLAG_W-1:0]  flags;

  assign valid_o = s1_valid;  // one cycle ahead of writeback

  fp32_align u_align (
    .clk(clk), .rst(rst), .flush_i(flush_i), .adv_i(adv_i), .rmode_i(rmode_i),
    .add_rdy_i(add_rdy_i), .add_sign_i(add_sign_i), .add_sub_0_i(add_sub_0_i),
    .add_shl_i(add_shl_i), .add_exp_shl_i(add_exp_shl_i),
    .add_exp_sh0_i(add_exp_sh0_i), .add_fract_i(add_fract_i),
    .add_inv_i(add_inv_i), .add_inf_i(add_inf_i), .add_snan_i(add_snan_i),
    .add_qnan_i(add_qnan_i), .add_anan_sign_i(add_anan_sign_i),
    .mul_rdy_i(mul_rdy_i), .mul_sign_i(mul_sign_i), .mul_shr_i(mul_shr_i),
    .mul_exp_shr_i(mul_exp_shr_i), .mul_shl_i(mul_shl_i),
    .mul_exp_shl_i(mul_exp_shl_i), .mul_exp_sh0_i(mul_exp_sh0_i),
    .mul_fract_i(mul_fract_i), .mul_inv_i(mul_inv_i), .mul_inf_i(mul_inf_i),
    .mul_snan_i(mul_snan_i), .mul_qnan_i(mul_qnan_i),
    .mul_anan_sign_i(mul_anan_sign_i), .div_op_i(div_op_i),
    .div_sign_rmnd_i(div_sign_rmnd_i), .div_dbz_i(div_dbz_i),
    .s1_valid_o(s1_valid), .s1_sign_o(s1_sign), .s1_exp_o(s1_exp),
    .s1_fract_o(s1_fract), .s1_round_o(s1_round), .s1_sticky_o(s1_sticky),
    .s1_inv_o(s1_inv), .s1_inf_o(s1_inf), .s1_snan_o(s1_snan),
    .s1_qnan_o(s1_qnan), .s1_anan_sign_o(s1_anan_sign),
    .s1_div_op_o(s1_div_op), .s1_div_rmnd_o(s1_div_rmnd), .s1_dbz_o(s1_dbz)
  );

  fp32_round u_round (
    .rmode_i(rmode_i), .s1_sign_i(s1_sign), .s1_exp_i(s1_exp),
    .s1_fract_i(s1_fract), .s1_round_i(s1_round), .s1_sticky_i(s1_sticky),
    .s1_div_op_i(s1_div_op), .s1_div_rmnd_i(s1_div_rmnd),
    .rnd_exp_o(rnd_exp), .rnd_fract_o(rnd_fract), .lost_o(lost)
  );

  fp32_result_pack u_pack (
    .s1_sign_i(s1_sign), .s1_inv_i(s1_inv), .s1_inf_i(s1_inf),
    .s1_snan_i(s1_snan), .s1_qnan_i(s1_qnan), .s1_anan_sign_i(s1_anan_sign),
    .s1_dbz_i(s1_dbz), .rnd_exp_i(rnd_exp), .rnd_fract_i(rnd_fract),
    .lost_i(lost), .result_o(result), .flags_o(flags)
  );

  fp32_wb_latch u_wb (
    .clk(clk), .rst(rst), .flush_i(flush_i), .padv_wb_i(padv_wb_i),
    .grant_wb_i(grant_wb_i), .except_enable_i(except_enable_i),
    .flag_mask_i(flag_mask_i), .result_i(result), .flags_i(flags),
    .wb_result_o(wb_result_o), .wb_flags_o(wb_flags_o),
    .wb_fpcsr_o(wb_fpcsr_o), .wb_except_o(wb_except_o)
  );

endmodule

// ==== include/tb_fp32_model.svh ====
// fp32 rounding back end, reference model for the testbench
// aligns, rounds and packs one operation from the unit-side inputs
`ifndef TB_FP32_MODEL_SVH
`define TB_FP32_MODEL_SVH

function automatic void model_op(
  input  logic        use_add,
  input  logic        sign,
  input  logic        sub_0,
  input  logic [4:0]  shl,
  input  logic [4:0]  shr_req,
  input  logic [9:0]  e_shr,
  input  logic [9:0]  e_shl,
  input  logic [9:0]  e_sh0,
  input  logic [27:0] fract,
  input  logic        inv,
  input  logic        inf,
  input  logic        nan_in,    // snan or qnan
  input  logic        qnan,
  input  logic        nan_sign,
  input  logic        div,
  input  logic        rmnd,
  input  logic        dbz,
  input  logic [1:0]  rm,
  output logic [31:0] res,
  output logic [8:0]  flg
);
  logic [63:0] w;
  logic [63:0] sh;
  logic [4:0]  shr;
  logic [31:0] fr;
  logic [9:0]  ex;
  logic [23:0] f24;
  logic        carry, rnd, stk, lost, sgn, up, dn, toward, away;
  carry = fract[27];
  shr   = (shr_req != 0) ? shr_req : {4'b0, carry};  // carry forces one right
  w     = {36'b0, fract};
  if (shr != 0) begin
    sh  = w >> shr;
    stk = |(w & ((64'd1 << (int'(shr) + 2)) - 64'd1));  // everything under round
  end else begin
    sh  = w << shl;
    stk = |sh[1:0];
  end
  fr   = sh[34:3];
  rnd  = sh[2];
  lost = rnd | stk;
  if (shr_req != 0) ex = e_shr;
  else if (shl == 0) ex = e_sh0 + {9'b0, carry};
  else ex = e_shl;
  sgn = (use_add && sub_0) ? (rm == 2'd3) : sign;
  // plain rounding
  up = (rm == 2'd0 && rnd && (stk || fr[0])) ||
       (rm == 2'd2 && !sgn && lost) || (rm == 2'd3 && sgn && lost);
  dn = 1'b0;
  if (div && fr[23]) begin  // normalized quotient
    toward = (rm == 2'd2 && !sgn) || (rm == 2'd3 && sgn);
    away   = (rm == 2'd1) || (rm == 2'd2 && sgn) || (rm == 2'd3 && !sgn);
    up = (rm == 2'd0 && rnd && stk && !rmnd) || (toward && stk && (rnd || !rmnd));
    dn = away && !rnd && stk && rmnd;
  end
  fr = fr + {31'b0, up} - {31'b0, dn};
  if (fr[24]) begin
    f24 = fr[24:1];
    ex  = ex + 10'd1;
  end else begin
    f24 = fr[23:0];
  end
  flg = '0;
  flg[FLG_DBZ]  = dbz;
  flg[FLG_INV]  = inv;
  flg[FLG_SNAN] = inv;
  flg[FLG_QNAN] = qnan;
  if (nan_in) begin
    res = {nan_sign, 31'h7fc0_0000};
  end else if (inv) begin
    res = {sgn, 31'h7fbf_ffff};
  end else if (ex > 10'd254 || inf || dbz) begin
    res = {sgn, 31'h7f80_0000};
    flg[FLG_INF] = 1'b1;
    flg[FLG_INE] = (lost || !inf) && !dbz;
    flg[FLG_OVF] = !inf && !dbz;
  end else if (!f24[23]) begin
    res = {sgn, 8'd0, f24[22:0]};
    flg[FLG_UNF] = lost;
    flg[FLG_ZER] = (f24 == 0);
    flg[FLG_INE] = lost;
  end else begin
    res = {sgn, ex[7:0], f24[22:0]};
    flg[FLG_INE] = lost;
  end
endfunction

`endif

// ==== verif/tb_fp32_rnd.sv ====
// testbench for the fp32 rounding back end
// directed tasks with a reference model, writeback control checks
`timescale 1ns/1ps

module tb_fp32_rnd import fp32_rnd_pkg::*; ();

  logic clk = 1'b0, rst;
  logic flush_i, adv_i, padv_wb_i, grant_wb_i, except_enable_i;
  logic [1:0] rmode_i;
  logic [FLAG_W-1:0] flag_mask_i;
  logic add_rdy_i, add_sign_i, add_sub_0_i;
  logic [SHIFT_W-1:0] add_shl_i;
  logic [EXP_W-1:0] add_exp_shl_i, add_exp_sh0_i;
  logic [FRACT_IN_W-1:0] add_fract_i;
  logic add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_anan_sign_i;
  logic mul_rdy_i, mul_sign_i, mul_shl_i;
  logic [SHIFT_W-1:0] mul_shr_i;
  logic [EXP_W-1:0] mul_exp_shr_i, mul_exp_shl_i, mul_exp_sh0_i;
  logic [FRACT_IN_W-1:0] mul_fract_i;
  logic mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i, mul_anan_sign_i;
  logic div_op_i, div_sign_rmnd_i, div_dbz_i;
  logic valid_o, wb_fpcsr_o, wb_except_o;
  logic [31:0] wb_result_o;
  logic [FLAG_W-1:0] wb_flags_o;

  int unsigned err_res = 0, err_flg = 0, err_bit = 0, cycles = 0;
  logic [31:0] seed = 32'hbf5a_e770;
  logic [31:0] last_res;

  `include "tb_fp32_model.svh"

  fp32_rnd_top UUT (.*);

  always #5 clk = ~clk;

  // run limit, well above the directed sequence
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 4000) begin
      $display("timeout: simulation ran past the cycle limit");
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_result(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
    if (got !== exp) begin
      err_res++;
      $display("error %0t: %s result %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_flags(input logic [FLAG_W-1:0] got, input logic [FLAG_W-1:0] exp,
                             input string msg);
    if (got !== exp) begin
      err_flg++;
      $display("error %0t: %s flags %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      err_bit++;
      $display("error %0t: %s is %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic idle_inputs();
    {add_rdy_i, add_sign_i, add_sub_0_i, add_shl_i, add_exp_shl_i, add_exp_sh0_i} = '0;
    {add_fract_i, add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_anan_sign_i} = '0;
    {mul_rdy_i, mul_sign_i, mul_shr_i, mul_exp_shr_i, mul_shl_i, mul_exp_shl_i} = '0;
    {mul_exp_sh0_i, mul_fract_i, mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i} = '0;
    {mul_anan_sign_i, div_op_i, div_sign_rmnd_i, div_dbz_i} = '0;
  endtask

  // expected word and flags for the inputs now on the bus
  task automatic expect_now(output logic [31:0] res, output logic [FLAG_W-1:0] flg);
    if (add_rdy_i)
      model_op(1'b1, add_sign_i, add_sub_0_i, add_shl_i, 5'd0, 10'd0, add_exp_shl_i,
               add_exp_sh0_i, add_fract_i, add_inv_i, add_inf_i, add_snan_i | add_qnan_i,
               add_qnan_i, add_anan_sign_i, 1'b0, div_sign_rmnd_i, div_dbz_i, rmode_i,
               res, flg);
    else
      model_op(1'b0, mul_sign_i, 1'b0, {4'b0, mul_shl_i}, mul_shr_i, mul_exp_shr_i,
               mul_exp_shl_i, mul_exp_sh0_i, mul_fract_i, mul_inv_i, mul_inf_i,
               mul_snan_i | mul_qnan_i, mul_qnan_i, mul_anan_sign_i, div_op_i,
               div_sign_rmnd_i, div_dbz_i, rmode_i, res, flg);
  endtask

  // one writeback advance, then the latch outputs and the strobe
  task automatic writeback_and_check(input logic [31:0] e_res,
                                     input logic [FLAG_W-1:0] e_flg,
                                     input logic grant, input string msg);
    logic [31:0] m_res;
    logic [FLAG_W-1:0] m_flg;
    padv_wb_i  = 1'b1;
    grant_wb_i = grant;
    @(negedge clk);
    padv_wb_i = 1'b0;
    m_res = e_res & {32{grant}};
    m_flg = e_flg & flag_mask_i & {FLAG_W{grant}};
    last_res = m_res;
    check_result(wb_result_o, m_res, msg);
    check_flags(wb_flags_o, m_flg, msg);
    check_bit(wb_except_o, except_enable_i & (|m_flg), {msg, " except_o"});
    check_bit(wb_fpcsr_o, grant, {msg, " fpcsr strobe"});
    @(negedge clk);
    check_bit(wb_fpcsr_o, 1'b0, {msg, " fpcsr after one cycle"});
  endtask

  // one accept, one writeback advance, then check
  task automatic issue_and_check(input logic grant, input string msg);
    logic [31:0] e_res;
    logic [FLAG_W-1:0] e_flg;
    expect_now(e_res, e_flg);
    adv_i = 1'b1;
    @(negedge clk);
    adv_i = 1'b0;
    check_bit(valid_o, 1'b1, {msg, " valid_o"});
    writeback_and_check(e_res, e_flg, grant, msg);
    idle_inputs();
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic add_rounding();
    logic [31:0] r;
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 8; i++) begin
        r = lcg_next();
        rmode_i       = m[1:0];
        add_rdy_i     = 1'b1;
        add_sign_i    = r[31];
        add_shl_i     = 5'(r[29:28] % 3);
        add_exp_shl_i = 10'd100 + 10'(r[27:24]);
        add_exp_sh0_i = 10'd120;
        add_fract_i   = {2'b01, r[25:0]} >> add_shl_i;  // hidden bit lands on 26
        issue_and_check(1'b1, "add round");
      end
    end
  endtask

  task automatic mul_shift_sticky();
    logic [31:0] r;
    logic [31:0] q;
    rmode_i = RM_NEAREST;
    for (int i = 0; i < 24; i++) begin
      r = lcg_next();
      mul_rdy_i     = 1'b1;
      mul_sign_i    = r[30];
      mul_shr_i     = 5'(r[31:27] % 27);  // up to the sticky saturation point
      mul_exp_shr_i = 10'd3;
      mul_exp_sh0_i = 10'd120;
      q = lcg_next();
      mul_fract_i   = {2'b01, q[31:6]};
      issue_and_check(1'b1, "mul shift");
    end
    mul_rdy_i = 1'b1;  // huge exponent overflows
    mul_exp_sh0_i = 10'd300;
    mul_fract_i = 28'h4abc_def;
    issue_and_check(1'b1, "mul overflow");
    mul_rdy_i = 1'b1;  // carry renormalizes into the top exponent
    mul_exp_sh0_i = 10'd253;
    mul_fract_i = 28'h8ff_fff3;
    issue_and_check(1'b1, "mul carry");
    mul_rdy_i = 1'b1;  // sticky only, rounds to zero
    mul_fract_i = 28'h000_0001;
    issue_and_check(1'b1, "mul underflow zero");
  endtask

  task automatic special_operands();
    rmode_i = RM_NEAREST;
    mul_rdy_i = 1'b1;
    mul_qnan_i = 1'b1;
    mul_anan_sign_i = 1'b1;
    mul_fract_i = 28'h4123_456;
    issue_and_check(1'b1, "qnan in");
    add_rdy_i = 1'b1;
    add_snan_i = 1'b1;
    issue_and_check(1'b1, "snan in");
    add_rdy_i = 1'b1;
    add_inv_i = 1'b1;
    add_sign_i = 1'b1;
    issue_and_check(1'b1, "invalid");
    for (int m = 0; m < 4; m++) begin
      rmode_i     = m[1:0];
      add_rdy_i   = 1'b1;
      add_sub_0_i = 1'b1;
      add_sign_i  = 1'b1;  // sign comes from the mode alone
      issue_and_check(1'b1, "sub zero sign");
    end
  endtask

  task automatic div_quotient();
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 4; k++) begin
        rmode_i         = m[1:0];
        mul_rdy_i       = 1'b1;
        div_op_i        = 1'b1;
        mul_sign_i      = k[1];
        div_sign_rmnd_i = k[0];
        mul_exp_sh0_i   = 10'd127;
        mul_fract_i     = {2'b01, 23'h2a_5a5a, 3'b001};  // sticky alone
        issue_and_check(1'b1, "div normal quotient");
      end
      rmode_i = m[1:0];
      mul_rdy_i = 1'b1;
      div_op_i = 1'b1;
      div_sign_rmnd_i = 1'b1;
      mul_fract_i = 28'h000_0ffd;
      issue_and_check(1'b1, "div denormal quotient");
    end
    mul_rdy_i = 1'b1;
    div_op_i = 1'b1;
    div_dbz_i = 1'b1;
    mul_exp_sh0_i = 10'd127;
    mul_fract_i = 28'h400_0000;
    issue_and_check(1'b1, "div by zero");
  endtask

  task automatic writeback_control();
    logic [31:0] held;
    logic [31:0] e_res;
    logic [FLAG_W-1:0] e_flg;
    rmode_i = RM_NEAREST;
    except_enable_i = 1'b1;
    flag_mask_i = 9'b1_0110_1001;
    mul_rdy_i = 1'b1;
    mul_exp_sh0_i = 10'd400;
    mul_fract_i = 28'h4000_005;
    issue_and_check(1'b1, "masked overflow");
    flag_mask_i = '1;
    mul_rdy_i = 1'b1;
    mul_exp_sh0_i = 10'd400;
    issue_and_check(1'b0, "no grant");
    mul_rdy_i = 1'b1;
    mul_exp_sh0_i = 10'd400;
    issue_and_check(1'b1, "except raised");
    held = last_res;
    // flush on an accepting edge
    add_rdy_i = 1'b1;
    add_fract_i = 28'h400_0000;
    adv_i = 1'b1;
    flush_i = 1'b1;
    @(negedge clk);
    {adv_i, flush_i} = 2'b00;
    idle_inputs();
    check_bit(valid_o, 1'b0, "valid_o after flush");
    check_flags(wb_flags_o, '0, "after flush");
    check_bit(wb_except_o, 1'b0, "except_o after flush");
    check_result(wb_result_o, held, "after flush");
    except_enable_i = 1'b0;
    // stage one holds while adv_i is low
    add_rdy_i = 1'b1;
    add_exp_sh0_i = 10'd130;
    add_fract_i = 28'h5a5_a5a0;
    expect_now(e_res, e_flg);
    adv_i = 1'b1;
    @(negedge clk);
    adv_i = 1'b0;
    idle_inputs();
    add_fract_i = 28'h7ff_fff8;  // new bus value, not sampled
    repeat (3) @(negedge clk);
    check_bit(valid_o, 1'b1, "valid_o held");
    check_result(wb_result_o, held, "held result");
    writeback_and_check(e_res, e_flg, 1'b1, "after hold");
    idle_inputs();
  endtask

  initial begin
    rst = 1'b1;
    {flush_i, adv_i, padv_wb_i, grant_wb_i, except_enable_i} = '0;
    rmode_i = RM_NEAREST;
    flag_mask_i = '1;
    idle_inputs();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit(valid_o, 1'b0, "valid_o after reset");
    check_result(wb_result_o, '0, "after reset");
    check_flags(wb_flags_o, '0, "after reset");
    check_bit(wb_fpcsr_o, 1'b0, "fpcsr after reset");
    check_bit(wb_except_o, 1'b0, "except_o after reset");
    add_rounding();
    mul_shift_sticky();
    special_operands();
    div_quotient();
    writeback_control();
    $display("error counts: result %0d, flags %0d, bits %0d", err_res, err_flg, err_bit);
    if (err_res + err_flg + err_bit == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
source/fp32_rnd_pkg.sv
source/fp32_align.sv
source/fp32_round.sv
source/fp32_result_pack.sv
source/fp32_wb_latch.sv
source/fp32_rnd_top.sv
verif/tb_fp32_rnd.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fp32 rounding testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_fp32_rnd -o tb_fp32_rnd \
  && ./obj_dir/tb_fp32_rnd > sim.log 2>&1 \
  || { echo "build or run failed"; exit 1; }
grep -qx "All tests passed!" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
